// ==== verilog/isa_pkg.sv ====
package isa_pkg;

  // kind of execution unit an instruction needs
  typedef enum logic [2:0] {
    UC_ALU    = 3'd0,
    UC_LOAD   = 3'd1,
    UC_STORE  = 3'd2,
    UC_MULDIV = 3'd3,
    UC_BRANCH = 3'd4,
    UC_JUMP   = 3'd5
  } unit_class_e;

  // branch condition, evaluated on operand a (and b for eq/ne)
  typedef enum logic [2:0] {
    COND_UNCOND = 3'd0,
    COND_EQ     = 3'd1,
    COND_NE     = 3'd2,
    COND_GT     = 3'd3,
    COND_GE     = 3'd4,
    COND_LT     = 3'd5,
    COND_LE     = 3'd6
  } branch_cond_e;

  // decoded instruction as it sits in the instruction queue
  typedef struct packed {
    logic [31:0]  pc;
    unit_class_e  uclass;
    branch_cond_e cond;
    // jump target taken from operand a
    logic         rformat;
    logic [31:0]  branch_target;
    logic [4:0]   a_reg;
    logic         a_reg_valid;
    logic [4:0]   b_reg;
    logic         b_reg_valid;
    logic [4:0]   dest_reg;
    logic         dest_reg_valid;
  } dec_inst_t;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

  import isa_pkg::*;

  // instructions examined per cycle at the queue head
  localparam int ISSUE_WIDTH = 4;
  localparam int ROB_IDX_BITS = 4;
  localparam int TAKE_BITS = $clog2(ISSUE_WIDTH);

  typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

  // number of instructions taken, minus one
  typedef logic [TAKE_BITS-1:0] take_count_t;

  typedef struct packed {
    dec_inst_t inst;
    rob_idx_t  rob_idx;
  } iq_entry_t;

  // reorder buffer answer for one source operand
  typedef struct packed {
    logic [31:0] value;
    logic        present;
    logic        valid;
  } rob_lookup_t;

  // everything an execution unit needs to start work
  typedef struct packed {
    dec_inst_t   inst;
    logic [31:0] a;
    logic [31:0] b;
    rob_idx_t    rob_idx;
  } issue_pkt_t;

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        ready;
  } slot_ops_t;

  // link value written back by the branch unit
  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  dest_reg;
    logic        dest_reg_valid;
    logic        pc_valid;
  } rob_wr_t;

endpackage

// ==== verilog/operand_resolve.sv ====
module operand_resolve (
  input  logic                  a_reg_valid,
  input  logic                  b_reg_valid,
  input  pipe_pkg::rob_lookup_t rob_a,
  input  pipe_pkg::rob_lookup_t rob_b,
  input  logic [31:0]           rf_a,
  input  logic [31:0]           rf_b,
  output pipe_pkg::slot_ops_t   ops
);

  logic a_ok;
  logic b_ok;

  // a value held in the rob is newer than the register file copy
  assign ops.a = rob_a.present ? rob_a.value : rf_a;
  assign ops.b = rob_b.present ? rob_b.value : rf_b;

  // not in the rob means the register file is up to date,
  // otherwise the rob entry must already have its result
  assign a_ok = !rob_a.present || rob_a.valid;
  assign b_ok = !rob_b.present || rob_b.valid;

  // unused sources never hold up issue
  assign ops.ready = (a_ok || !a_reg_valid) && (b_ok || !b_reg_valid);

endmodule

// ==== verilog/dispatch_select.sv ====
module dispatch_select (
  input  logic [pipe_pkg::ISSUE_WIDTH-1:0] iq_valid,
  input  pipe_pkg::iq_entry_t              iq_entries [pipe_pkg::ISSUE_WIDTH],
  input  pipe_pkg::slot_ops_t              ops [pipe_pkg::ISSUE_WIDTH],
  input  logic                             ls_ready,
  input  logic                             alu_ready,
  input  logic                             mul_ready,
  input  logic                             branch_ready,
  input  logic                             branch_flush,
  output logic                             iq_take,
  output pipe_pkg::take_count_t            iq_take_count,
  output pipe_pkg::issue_pkt_t             ls_issue,
  output pipe_pkg::issue_pkt_t             alu_issue,
  output pipe_pkg::issue_pkt_t             mul_issue,
  output logic                             ls_valid,
  output logic                             alu_valid,
  output logic                             mul_valid,
  output pipe_pkg::issue_pkt_t             branch_pkt,
  output logic                             branch_sel
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic ls_used;
  logic alu_used;
  logic mul_used;
  logic ls_spec;
  logic alu_spec;
  logic mul_spec;
  int   taken;

  // can a non-branch instruction of this class go anywhere right now
  function automatic logic can_place(unit_class_e uc, logic ls_free, logic alu_free,
                                     logic mul_free);
    case (uc)
      UC_LOAD, UC_STORE: return ls_free;
      UC_MULDIV:         return mul_free;
      UC_ALU:            return alu_free || mul_free;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic issue_pkt_t make_pkt(iq_entry_t entry, slot_ops_t slot);
    issue_pkt_t pkt;
    pkt.inst    = entry.inst;
    pkt.a       = slot.a;
    pkt.b       = slot.b;
    pkt.rob_idx = entry.rob_idx;
    return pkt;
  endfunction

  always_comb begin
    logic        br_used;
    logic        spec;
    logic        done;
    logic        ls_free;
    logic        alu_free;
    logic        mul_free;
    int          br_idx;
    int          nxt;
    unit_class_e uc;

    br_used  = 1'b0;
    spec     = 1'b0;
    done     = 1'b0;
    br_idx   = 0;
    ls_used  = 1'b0;
    alu_used = 1'b0;
    mul_used = 1'b0;
    ls_spec  = 1'b0;
    alu_spec = 1'b0;
    mul_spec = 1'b0;
    taken    = 0;

    // payloads default to slot 0, only the valids carry meaning
    ls_issue   = make_pkt(iq_entries[0], ops[0]);
    alu_issue  = make_pkt(iq_entries[0], ops[0]);
    mul_issue  = make_pkt(iq_entries[0], ops[0]);
    branch_pkt = make_pkt(iq_entries[0], ops[0]);

    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      ls_free  = !ls_used && ls_ready;
      alu_free = !alu_used && alu_ready;
      mul_free = !mul_used && mul_ready;
      uc       = iq_entries[i].inst.uclass;
      nxt      = (i < ISSUE_WIDTH - 1) ? i + 1 : i;

      // strictly in order, so the first gap or stuck slot ends the walk
      if (!done && (!iq_valid[i] || !ops[i].ready)) begin
        done = 1'b1;
      end else if (!done) begin
        // anything past the delay slot may be thrown away
        if (br_used && i > br_idx + 1) begin
          spec = 1'b1;
        end

        // a branch only goes together with its delay slot
        if ((uc == UC_BRANCH || uc == UC_JUMP) && !br_used && branch_ready &&
            i != ISSUE_WIDTH - 1 && iq_valid[nxt] && ops[nxt].ready &&
            can_place(iq_entries[nxt].inst.uclass, ls_free, alu_free, mul_free)) begin
          br_used    = 1'b1;
          br_idx     = i;
          branch_pkt = make_pkt(iq_entries[i], ops[i]);
          taken      = taken + 1;
        end else if ((uc == UC_LOAD || uc == UC_STORE) && ls_free) begin
          ls_used  = 1'b1;
          ls_spec  = spec;
          ls_issue = make_pkt(iq_entries[i], ops[i]);
          taken    = taken + 1;
        end else if (uc == UC_ALU && alu_free) begin
          alu_used  = 1'b1;
          alu_spec  = spec;
          alu_issue = make_pkt(iq_entries[i], ops[i]);
          taken     = taken + 1;
        end else if ((uc == UC_MULDIV || uc == UC_ALU) && mul_free) begin
          // multiply unit also soaks up alu overflow
          mul_used  = 1'b1;
          mul_spec  = spec;
          mul_issue = make_pkt(iq_entries[i], ops[i]);
          taken     = taken + 1;
        end else begin
          done = 1'b1;
        end
      end
    end

    branch_sel = br_used;
  end

  assign iq_take       = (taken != 0);
  assign iq_take_count = take_count_t'(taken - 1);

  // squash work behind the delay slot when the branch redirects
  assign ls_valid  = ls_used && !(ls_spec && branch_flush);
  assign alu_valid = alu_used && !(alu_spec && branch_flush);
  assign mul_valid = mul_used && !(mul_spec && branch_flush);

endmodule

// ==== verilog/branch_unit.sv ====
module branch_unit (
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 branch_stall,
  input  pipe_pkg::issue_pkt_t branch_pkt,
  input  logic                 branch_sel,
  output logic                 branch_ready,
  output logic [31:0]          new_pc,
  output logic                 new_pc_valid,
  output logic                 branch_flush,
  output logic                 rob_wr_valid,
  output pipe_pkg::rob_idx_t   rob_wr_slot,
  output pipe_pkg::rob_wr_t    rob_wr
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic        stall_q;
  logic        held_sel;
  issue_pkt_t  held_pkt;
  logic        stall_rise;
  issue_pkt_t  act_pkt;
  logic        act_sel;
  logic [31:0] op_a;
  logic        ab_equal;
  logic        a_eqz;
  logic        a_gez;
  logic        a_gtz;
  logic        cond_ok;

  assign stall_rise = branch_stall && !stall_q;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_q  <= 1'b0;
      held_sel <= 1'b0;
    end else begin
      stall_q <= branch_stall;
      if (stall_rise) begin
        held_sel <= branch_sel;
      end
    end
  end

  // branch copy kept for the length of a fetch stall
  always_ff @(posedge clock) begin
    if (stall_rise) begin
      held_pkt <= branch_pkt;
    end
  end

  assign branch_ready = !stall_q;
  assign act_pkt      = stall_q ? held_pkt : branch_pkt;
  assign act_sel      = stall_q ? held_sel : branch_sel;

  assign op_a     = act_pkt.a;
  assign ab_equal = (op_a == act_pkt.b);
  assign a_eqz    = (op_a == 32'd0);
  assign a_gez    = !op_a[31];
  assign a_gtz    = a_gez && !a_eqz;

  always_comb begin
    case (act_pkt.inst.cond)
      COND_UNCOND: cond_ok = 1'b1;
      COND_EQ:     cond_ok = ab_equal;
      COND_NE:     cond_ok = !ab_equal;
      COND_GT:     cond_ok = a_gtz;
      COND_GE:     cond_ok = a_gez;
      COND_LT:     cond_ok = !a_gez;
      COND_LE:     cond_ok = !a_gtz;
      default:     cond_ok = 1'b0;
    endcase
  end

  // jumps always redirect, branches only when the condition holds
  assign new_pc_valid = act_sel &&
                        (act_pkt.inst.uclass == UC_JUMP ||
                         (act_pkt.inst.uclass == UC_BRANCH && cond_ok));
  assign new_pc       = act_pkt.inst.rformat ? op_a : act_pkt.inst.branch_target;

  // the flush is raised once, not again while the stall persists
  assign branch_flush = new_pc_valid && !stall_q;

  // link value is the address after the delay slot
  assign rob_wr_valid          = act_sel && !branch_stall;
  assign rob_wr_slot           = act_pkt.rob_idx;
  assign rob_wr.result         = act_pkt.inst.pc + 32'd8;
  assign rob_wr.dest_reg       = act_pkt.inst.dest_reg;
  assign rob_wr.dest_reg_valid = act_pkt.inst.dest_reg_valid;
  assign rob_wr.pc_valid       = new_pc_valid;

endmodule

// ==== verilog/issue_stage.sv ====
module issue_stage (
  input  logic                             clock,
  input  logic                             reset_n,
  input  logic [pipe_pkg::ISSUE_WIDTH-1:0] iq_valid,
  input  pipe_pkg::iq_entry_t              iq_entries [pipe_pkg::ISSUE_WIDTH],
  output logic                             iq_take,
  output pipe_pkg::take_count_t            iq_take_count,
  output pipe_pkg::rob_idx_t               rob_query_idx [pipe_pkg::ISSUE_WIDTH],
  output logic [4:0]                       rob_a_reg [pipe_pkg::ISSUE_WIDTH],
  output logic [4:0]                       rob_b_reg [pipe_pkg::ISSUE_WIDTH],
  input  pipe_pkg::rob_lookup_t            rob_a [pipe_pkg::ISSUE_WIDTH],
  input  pipe_pkg::rob_lookup_t            rob_b [pipe_pkg::ISSUE_WIDTH],
  output logic [4:0]                       rf_addr [2*pipe_pkg::ISSUE_WIDTH],
  input  logic [31:0]                      rf_data [2*pipe_pkg::ISSUE_WIDTH],
  output pipe_pkg::issue_pkt_t             ls_issue,
  output logic                             ls_valid,
  input  logic                             ls_ready,
  output pipe_pkg::issue_pkt_t             alu_issue,
  output logic                             alu_valid,
  input  logic                             alu_ready,
  output pipe_pkg::issue_pkt_t             mul_issue,
  output logic                             mul_valid,
  input  logic                             mul_ready,
  input  logic                             branch_stall,
  output logic [31:0]                      new_pc,
  output logic                             new_pc_valid,
  output logic                             branch_flush,
  output logic                             rob_wr_valid,
  output pipe_pkg::rob_idx_t               rob_wr_slot,
  output pipe_pkg::rob_wr_t                rob_wr
);

  import pipe_pkg::*;

  slot_ops_t  slot_ops [ISSUE_WIDTH];
  issue_pkt_t branch_pkt;
  logic       branch_sel;
  logic       branch_ready;

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
    // same source registers go to both the rob and the register file
    assign rob_query_idx[i] = iq_entries[i].rob_idx;
    assign rob_a_reg[i]     = iq_entries[i].inst.a_reg;
    assign rob_b_reg[i]     = iq_entries[i].inst.b_reg;
    assign rf_addr[2*i]     = iq_entries[i].inst.a_reg;
    assign rf_addr[2*i+1]   = iq_entries[i].inst.b_reg;

    operand_resolve u_resolve (
      .a_reg_valid (iq_entries[i].inst.a_reg_valid),
      .b_reg_valid (iq_entries[i].inst.b_reg_valid),
      .rob_a       (rob_a[i]),
      .rob_b       (rob_b[i]),
      .rf_a        (rf_data[2*i]),
      .rf_b        (rf_data[2*i+1]),
      .ops         (slot_ops[i])
    );
  end

  dispatch_select u_dispatch (
    .iq_valid      (iq_valid),
    .iq_entries    (iq_entries),
    .ops           (slot_ops),
    .ls_ready      (ls_ready),
    .alu_ready     (alu_ready),
    .mul_ready     (mul_ready),
    .branch_ready  (branch_ready),
    .branch_flush  (branch_flush),
    .iq_take       (iq_take),
    .iq_take_count (iq_take_count),
    .ls_issue      (ls_issue),
    .alu_issue     (alu_issue),
    .mul_issue     (mul_issue),
    .ls_valid      (ls_valid),
    .alu_valid     (alu_valid),
    .mul_valid     (mul_valid),
    .branch_pkt    (branch_pkt),
    .branch_sel    (branch_sel)
  );

  branch_unit u_branch (
    .clock        (clock),
    .reset_n      (reset_n),
    .branch_stall (branch_stall),
    .branch_pkt   (branch_pkt),
    .branch_sel   (branch_sel),
    .branch_ready (branch_ready),
    .new_pc       (new_pc),
    .new_pc_valid (new_pc_valid),
    .branch_flush (branch_flush),
    .rob_wr_valid (rob_wr_valid),
    .rob_wr_slot  (rob_wr_slot),
    .rob_wr       (rob_wr)
  );

endmodule

// ==== dv/issue_checks.svh ====
`ifndef ISSUE_CHECKS_SVH
`define ISSUE_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_bit(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_pkt(input string name, input issue_pkt_t got, input issue_pkt_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_rob_wr(input string name, input rob_wr_t got, input rob_wr_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_slot(input string name, input rob_idx_t got, input rob_idx_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_take(input string name, input take_count_t got, input take_count_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
  end
endtask

`endif

// ==== dv/issue_tb.sv ====
module issue_tb;

  import isa_pkg::*;
  import pipe_pkg::*;

  // six short tests of about 40 cycles each, with margin
  localparam int TIMEOUT_CYCLES = 400;

  logic                   clock;
  logic                   reset_n;
  logic [ISSUE_WIDTH-1:0] iq_valid;
  iq_entry_t              iq_entries [ISSUE_WIDTH];
  logic                   iq_take;
  take_count_t            iq_take_count;
  rob_idx_t               rob_query_idx [ISSUE_WIDTH];
  logic [4:0]             rob_a_reg [ISSUE_WIDTH];
  logic [4:0]             rob_b_reg [ISSUE_WIDTH];
  rob_lookup_t            rob_a [ISSUE_WIDTH];
  rob_lookup_t            rob_b [ISSUE_WIDTH];
  logic [4:0]             rf_addr [2*ISSUE_WIDTH];
  logic [31:0]            rf_data [2*ISSUE_WIDTH];
  issue_pkt_t             ls_issue;
  logic                   ls_valid;
  logic                   ls_ready;
  issue_pkt_t             alu_issue;
  logic                   alu_valid;
  logic                   alu_ready;
  issue_pkt_t             mul_issue;
  logic                   mul_valid;
  logic                   mul_ready;
  logic                   branch_stall;
  logic [31:0]            new_pc;
  logic                   new_pc_valid;
  logic                   branch_flush;
  logic                   rob_wr_valid;
  rob_idx_t               rob_wr_slot;
  rob_wr_t                rob_wr;
  int                     cycles = 0;

  `include "issue_checks.svh"

  issue_stage uut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  task automatic next_cycle();
    @(negedge clock);
  endtask

  // outputs are combinational, sample shortly before the next rising edge
  task automatic settle();
    #3;
  endtask

  function automatic dec_inst_t make_inst(unit_class_e uc, branch_cond_e cond, logic rformat,
                                          logic [31:0] pc, logic [31:0] target);
    dec_inst_t inst;
    inst.pc             = pc;
    inst.uclass         = uc;
    inst.cond           = cond;
    inst.rformat        = rformat;
    inst.branch_target  = target;
    inst.a_reg          = 5'd1;
    inst.a_reg_valid    = 1'b1;
    inst.b_reg          = 5'd2;
    inst.b_reg_valid    = 1'b1;
    inst.dest_reg       = 5'd31;
    inst.dest_reg_valid = 1'b1;
    return inst;
  endfunction

  function automatic issue_pkt_t expected_pkt(iq_entry_t entry, logic [31:0] a, logic [31:0] b);
    issue_pkt_t pkt;
    pkt.inst    = entry.inst;
    pkt.a       = a;
    pkt.b       = b;
    pkt.rob_idx = entry.rob_idx;
    return pkt;
  endfunction

  // packet for a slot whose operands come from the register file
  function automatic issue_pkt_t slot_pkt(int i);
    return expected_pkt(iq_entries[i], rf_data[2*i], rf_data[2*i+1]);
  endfunction

  task automatic clear_inputs();
    iq_valid     = '0;
    ls_ready     = 1'b1;
    alu_ready    = 1'b1;
    mul_ready    = 1'b1;
    branch_stall = 1'b0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      iq_entries[i] = '0;
      rob_a[i]      = '0;
      rob_b[i]      = '0;
    end
    for (int j = 0; j < 2 * ISSUE_WIDTH; j++) begin
      rf_data[j] = $urandom();
    end
  endtask

  task automatic put_slot(input int i, input dec_inst_t inst);
    iq_entries[i].inst    = inst;
    iq_entries[i].rob_idx = rob_idx_t'(i + 5);
    iq_valid[i]           = 1'b1;
  endtask

  // branch, delay slot alu, then a load and a multiply behind it
  task automatic fill_branch_group(input dec_inst_t br);
    put_slot(0, br);
    put_slot(1, make_inst(UC_ALU, COND_UNCOND, 1'b0, br.pc + 32'd4, 32'd0));
    put_slot(2, make_inst(UC_LOAD, COND_UNCOND, 1'b0, br.pc + 32'd8, 32'd0));
    put_slot(3, make_inst(UC_MULDIV, COND_UNCOND, 1'b0, br.pc + 32'd12, 32'd0));
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, error_count - errs_before);
    end
  endtask

  task automatic test_reset_idle();
    int errs;
    errs = error_count;
    next_cycle();
    clear_inputs();
    settle();
    check_bit("iq_take", iq_take, 1'b0);
    check_bit("ls_valid", ls_valid, 1'b0);
    check_bit("alu_valid", alu_valid, 1'b0);
    check_bit("mul_valid", mul_valid, 1'b0);
    check_bit("new_pc_valid", new_pc_valid, 1'b0);
    check_bit("branch_flush", branch_flush, 1'b0);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b0);
    report_test("reset_idle", errs);
  endtask

  task automatic test_operand_choice();
    int          errs;
    logic [31:0] rob_val;
    errs    = error_count;
    rob_val = $urandom();
    next_cycle();
    clear_inputs();
    put_slot(0, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h100, 32'd0));
    rob_a[0] = '{value: rob_val, present: 1'b1, valid: 1'b1};
    settle();
    check_bit("iq_take", iq_take, 1'b1);
    check_take("iq_take_count", iq_take_count, 2'd0);
    check_bit("alu_valid", alu_valid, 1'b1);
    check_pkt("alu_issue", alu_issue, expected_pkt(iq_entries[0], rob_val, rf_data[1]));
    // result still pending in the rob blocks the slot
    next_cycle();
    rob_a[0].valid = 1'b0;
    settle();
    check_bit("iq_take", iq_take, 1'b0);
    check_bit("alu_valid", alu_valid, 1'b0);
    next_cycle();
    iq_entries[0].inst.a_reg_valid = 1'b0;
    settle();
    check_bit("iq_take", iq_take, 1'b1);
    check_bit("alu_valid", alu_valid, 1'b1);
    check_pkt("alu_issue", alu_issue, expected_pkt(iq_entries[0], rob_val, rf_data[1]));
    report_test("operand_choice", errs);
  endtask

  task automatic test_in_order();
    int errs;
    errs = error_count;
    next_cycle();
    clear_inputs();
    put_slot(0, make_inst(UC_LOAD, COND_UNCOND, 1'b0, 32'h200, 32'd0));
    put_slot(1, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h204, 32'd0));
    put_slot(2, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h208, 32'd0));
    put_slot(3, make_inst(UC_MULDIV, COND_UNCOND, 1'b0, 32'h20c, 32'd0));
    // distinct source registers per slot so each lookup port can be told apart
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      iq_entries[i].inst.a_reg = 5'(3 + 2 * i);
      iq_entries[i].inst.b_reg = 5'(4 + 2 * i);
    end
    settle();
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      check_slot($sformatf("rob_query_idx[%0d]", i), rob_query_idx[i], rob_idx_t'(i + 5));
      check_reg($sformatf("rob_a_reg[%0d]", i), rob_a_reg[i], 5'(3 + 2 * i));
      check_reg($sformatf("rob_b_reg[%0d]", i), rob_b_reg[i], 5'(4 + 2 * i));
      check_reg($sformatf("rf_addr[%0d]", 2 * i), rf_addr[2 * i], 5'(3 + 2 * i));
      check_reg($sformatf("rf_addr[%0d]", 2 * i + 1), rf_addr[2 * i + 1], 5'(4 + 2 * i));
    end
    check_take("iq_take_count", iq_take_count, 2'd2);
    check_bit("ls_valid", ls_valid, 1'b1);
    check_pkt("ls_issue", ls_issue, slot_pkt(0));
    check_bit("alu_valid", alu_valid, 1'b1);
    check_pkt("alu_issue", alu_issue, slot_pkt(1));
    check_bit("mul_valid", mul_valid, 1'b1);
    check_pkt("mul_issue", mul_issue, slot_pkt(2));
    // second load has nowhere to go
    next_cycle();
    put_slot(1, make_inst(UC_LOAD, COND_UNCOND, 1'b0, 32'h204, 32'd0));
    settle();
    check_take("iq_take_count", iq_take_count, 2'd0);
    check_bit("ls_valid", ls_valid, 1'b1);
    check_bit("alu_valid", alu_valid, 1'b0);
    check_bit("mul_valid", mul_valid, 1'b0);
    next_cycle();
    ls_ready = 1'b0;
    settle();
    check_bit("iq_take", iq_take, 1'b0);
    check_bit("ls_valid", ls_valid, 1'b0);
    report_test("in_order", errs);
  endtask

  task automatic test_invalid_gap();
    int errs;
    errs = error_count;
    next_cycle();
    clear_inputs();
    put_slot(0, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h300, 32'd0));
    put_slot(2, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h308, 32'd0));
    put_slot(3, make_inst(UC_MULDIV, COND_UNCOND, 1'b0, 32'h30c, 32'd0));
    settle();
    check_bit("iq_take", iq_take, 1'b1);
    check_take("iq_take_count", iq_take_count, 2'd0);
    check_bit("alu_valid", alu_valid, 1'b1);
    check_pkt("alu_issue", alu_issue, slot_pkt(0));
    check_bit("mul_valid", mul_valid, 1'b0);
    report_test("invalid_gap", errs);
  endtask

  // operand a is compared with zero, a and b with each other
  task automatic pick_taken_operands(input branch_cond_e cond, output logic [31:0] a,
                                     output logic [31:0] b);
    a = $urandom();
    b = $urandom();
    case (cond)
      COND_EQ: b = a;
      COND_NE: b = ~a;
      COND_GT: a = {1'b0, a[30:1], 1'b1};
      COND_GE: a[31] = 1'b0;
      COND_LT: a[31] = 1'b1;
      COND_LE: a[31] = 1'b1;
      default: b = a;
    endcase
  endtask

  task automatic run_taken_branch(input unit_class_e uc, input branch_cond_e cond,
                                  input logic rformat);
    dec_inst_t   br;
    rob_wr_t     exp_wr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_pc;
    pick_taken_operands(cond, a, b);
    br = make_inst(uc, cond, rformat, $urandom() & 32'hffff_fffc, $urandom() & 32'hffff_fffc);
    next_cycle();
    clear_inputs();
    fill_branch_group(br);
    rf_data[0] = a;
    rf_data[1] = b;
    settle();
    exp_pc = rformat ? a : br.branch_target;
    exp_wr = '{result: br.pc + 32'd8, dest_reg: br.dest_reg,
               dest_reg_valid: br.dest_reg_valid, pc_valid: 1'b1};
    check_bit("new_pc_valid", new_pc_valid, 1'b1);
    check_pc("new_pc", new_pc, exp_pc);
    check_bit("branch_flush", branch_flush, 1'b1);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b1);
    check_slot("rob_wr_slot", rob_wr_slot, iq_entries[0].rob_idx);
    check_rob_wr("rob_wr", rob_wr, exp_wr);
    check_take("iq_take_count", iq_take_count, 2'd3);
    check_bit("alu_valid", alu_valid, 1'b1);
    check_pkt("alu_issue", alu_issue, slot_pkt(1));
    check_bit("ls_valid", ls_valid, 1'b0);
    check_bit("mul_valid", mul_valid, 1'b0);
  endtask

  task automatic test_branches();
    int          errs;
    dec_inst_t   br;
    rob_wr_t     exp_wr;
    logic [31:0] a;
    errs = error_count;
    for (int c = 0; c <= 6; c++) begin
      run_taken_branch(UC_BRANCH, branch_cond_e'(c), 1'b0);
    end
    run_taken_branch(UC_JUMP, COND_UNCOND, 1'b1);
    // eq with unequal operands falls through
    a  = $urandom();
    br = make_inst(UC_BRANCH, COND_EQ, 1'b0, 32'h400, 32'h800);
    next_cycle();
    clear_inputs();
    fill_branch_group(br);
    rf_data[0] = a;
    rf_data[1] = a + 32'd1;
    settle();
    exp_wr = '{result: 32'h408, dest_reg: br.dest_reg,
               dest_reg_valid: br.dest_reg_valid, pc_valid: 1'b0};
    check_bit("new_pc_valid", new_pc_valid, 1'b0);
    check_bit("branch_flush", branch_flush, 1'b0);
    check_bit("ls_valid", ls_valid, 1'b1);
    check_bit("mul_valid", mul_valid, 1'b1);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b1);
    check_rob_wr("rob_wr", rob_wr, exp_wr);
    // no room for a delay slot in the last slot
    next_cycle();
    clear_inputs();
    put_slot(0, make_inst(UC_LOAD, COND_UNCOND, 1'b0, 32'h500, 32'd0));
    put_slot(1, make_inst(UC_ALU, COND_UNCOND, 1'b0, 32'h504, 32'd0));
    put_slot(2, make_inst(UC_MULDIV, COND_UNCOND, 1'b0, 32'h508, 32'd0));
    put_slot(3, make_inst(UC_BRANCH, COND_UNCOND, 1'b0, 32'h50c, 32'h900));
    settle();
    check_take("iq_take_count", iq_take_count, 2'd2);
    check_bit("new_pc_valid", new_pc_valid, 1'b0);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b0);
    next_cycle();
    clear_inputs();
    put_slot(0, make_inst(UC_BRANCH, COND_UNCOND, 1'b0, 32'h600, 32'ha00));
    put_slot(1, make_inst(UC_LOAD, COND_UNCOND, 1'b0, 32'h604, 32'd0));
    ls_ready = 1'b0;
    settle();
    check_bit("iq_take", iq_take, 1'b0);
    check_bit("new_pc_valid", new_pc_valid, 1'b0);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b0);
    report_test("branches", errs);
  endtask

  task automatic test_stall_hold();
    int errs;
    errs = error_count;
    next_cycle();
    clear_inputs();
    fill_branch_group(make_inst(UC_BRANCH, COND_UNCOND, 1'b0, 32'h700, 32'h1240));
    branch_stall = 1'b1;
    settle();
    check_bit("new_pc_valid", new_pc_valid, 1'b1);
    check_pc("new_pc", new_pc, 32'h1240);
    check_bit("branch_flush", branch_flush, 1'b1);
    check_bit("rob_wr_valid", rob_wr_valid, 1'b0);
    // queue moves on, the captured branch must not
    repeat (2) begin
      next_cycle();
      clear_inputs();
      fill_branch_group(make_inst(UC_BRANCH, COND_UNCOND, 1'b0, 32'h780, 32'h2480));
      branch_stall = 1'b1;
      settle();
      check_pc("new_pc", new_pc, 32'h1240);
      check_bit("new_pc_valid", new_pc_valid, 1'b1);
      check_bit("branch_flush", branch_flush, 1'b0);
      check_bit("rob_wr_valid", rob_wr_valid, 1'b0);
      check_bit("iq_take", iq_take, 1'b0);
    end
    next_cycle();
    clear_inputs();
    report_test("stall_hold", errs);
  endtask

  initial begin
    void'($urandom(32'h6846_c443));
    reset_n = 1'b0;
    clear_inputs();
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    test_reset_idle();
    test_operand_choice();
    test_in_order();
    test_invalid_gap();
    test_branches();
    test_stall_hold();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+dv
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/operand_resolve.sv
verilog/dispatch_select.sv
verilog/branch_unit.sv
verilog/issue_stage.sv
dv/issue_tb.sv
